// File: hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width
`define XLEN 32

// register counts, r0 reads as zero
`define ARCH_REGS 8
`define PRF_SIZE 16

// queue depths
`define ROB_SIZE 8
`define RS_SIZE 4

// multiplier latency in cycles
`define MULT_STAGES 3

`endif

// File: hdl/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

	typedef logic [`XLEN-1:0] word_t;                   // one data word
	typedef logic [$clog2(`ARCH_REGS)-1:0] arn_t;       // architectural register
	typedef logic [$clog2(`PRF_SIZE)-1:0] prn_t;        // physical register
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;    // rob slot

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT                                         // signed compare
	} alu_op_t;

	typedef enum logic [0:0] {
		MUL_LO,                                         // low half of the product
		MUL_HI                                          // unsigned high half
	} mult_op_t;

	// top nibble of the dispatch word
	typedef enum logic [3:0] {
		OP_ADD    = 4'd0,
		OP_SUB    = 4'd1,
		OP_AND    = 4'd2,
		OP_OR     = 4'd3,
		OP_XOR    = 4'd4,
		OP_SLL    = 4'd5,
		OP_SRL    = 4'd6,
		OP_SLT    = 4'd7,
		OP_MUL_LO = 4'd8,
		OP_MUL_HI = 4'd9
	} opcode_t;

endpackage

// File: hdl/rename_map.sv
`include "core_settings.svh"

module rename_map import core_pkg::*; (
	input  logic clock,
	input  logic rst_n,
	input  logic alloc,              // rename rd at this edge
	input  arn_t rd,
	input  arn_t ra,
	input  arn_t rb,
	output prn_t src_a,
	output prn_t src_b,
	output prn_t new_prn,            // lowest free prn
	output prn_t old_prn,            // mapping that rd replaces
	output logic free_empty,
	input  logic release_en,         // retirement hands a prn back
	input  prn_t release_prn
);

	prn_t map_q [`ARCH_REGS];        // arn to prn
	logic [`PRF_SIZE-1:0] free_q;    // one bit per free prn

	assign src_a = map_q[ra];
	assign src_b = map_q[rb];
	assign old_prn = map_q[rd];
	assign free_empty = ~|free_q;

	always_comb begin
		new_prn = '0;
		for (int i = `PRF_SIZE - 1; i >= 0; i--) begin    // scan down so lowest wins
			if (free_q[i]) begin
				new_prn = prn_t'(i);
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `ARCH_REGS; i++) begin
				map_q[i] <= prn_t'(i);                        // identity mapping
			end
			free_q <= {{(`PRF_SIZE - `ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};
		end else begin
			if (alloc) begin
				map_q[rd] <= new_prn;
				free_q[new_prn] <= 1'b0;
			end
			if (release_en) begin
				free_q[release_prn] <= 1'b1;                  // old mapping is dead now
			end
		end
	end

	// the rob may only hand back a prn that is still in use
	assert property (@(posedge clock) disable iff (!rst_n)
		release_en |-> !free_q[release_prn]);

endmodule

// File: hdl/phys_regfile.sv
`include "core_settings.svh"

module phys_regfile import core_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	input  prn_t  rd_a,
	input  prn_t  rd_b,
	output word_t val_a,
	output word_t val_b,
	output logic  rdy_a,
	output logic  rdy_b,
	input  logic  alloc,             // new prn goes pending
	input  prn_t  alloc_prn,
	input  logic  cdb_valid,
	input  prn_t  cdb_tag,
	input  word_t cdb_value,
	input  prn_t  commit_prn,
	output word_t commit_value
);

	word_t val_q [`PRF_SIZE];
	logic [`PRF_SIZE-1:0] rdy_q;
	logic cdb_wr;
	logic fwd_a;
	logic fwd_b;

	assign cdb_wr = cdb_valid && cdb_tag != '0;          // prn 0 backs r0 and stays zero
	assign fwd_a = cdb_wr && cdb_tag == rd_a;
	assign fwd_b = cdb_wr && cdb_tag == rd_b;

	// same-cycle cdb bypass
	assign val_a = fwd_a ? cdb_value : val_q[rd_a];
	assign val_b = fwd_b ? cdb_value : val_q[rd_b];
	assign rdy_a = fwd_a || rdy_q[rd_a];
	assign rdy_b = fwd_b || rdy_q[rd_b];

	assign commit_value = val_q[commit_prn];             // written a cycle before retire

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PRF_SIZE; i++) begin
				val_q[i] <= '0;
			end
			rdy_q <= '1;
		end else begin
			if (alloc) begin
				rdy_q[alloc_prn] <= 1'b0;
			end
			if (cdb_wr) begin
				val_q[cdb_tag] <= cdb_value;
				rdy_q[cdb_tag] <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/reservation_station.sv
`include "core_settings.svh"

module reservation_station import core_pkg::*; #(
	parameter type op_t = logic      // opcode of the unit behind this station
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     load,
	input  op_t      load_op,
	input  word_t    load_a,
	input  word_t    load_b,
	input  logic     load_a_rdy,
	input  logic     load_b_rdy,
	input  prn_t     load_tag_a,
	input  prn_t     load_tag_b,
	input  prn_t     load_dest,
	input  rob_idx_t load_rob,
	output logic     full,
	input  logic     cdb_valid,
	input  prn_t     cdb_tag,
	input  word_t    cdb_value,
	input  logic     ready,          // unit takes an op this cycle
	output logic     issue_valid,
	output op_t      issue_op,
	output word_t    issue_a,
	output word_t    issue_b,
	output prn_t     issue_dest,
	output rob_idx_t issue_rob
);

	localparam int CW = $clog2(`RS_SIZE + 1);

	// slot 0 is the oldest, younger slots close up behind an issue
	logic [CW-1:0] count_q;
	logic [CW-1:0] load_pos;
	op_t      op_q    [`RS_SIZE];
	word_t    a_q     [`RS_SIZE];
	word_t    b_q     [`RS_SIZE];
	logic     a_rdy_q [`RS_SIZE];
	logic     b_rdy_q [`RS_SIZE];
	prn_t     tag_a_q [`RS_SIZE];
	prn_t     tag_b_q [`RS_SIZE];
	prn_t     dest_q  [`RS_SIZE];
	rob_idx_t rob_q   [`RS_SIZE];
	logic     found;
	int       pick;

	always_comb begin
		found = 1'b0;
		pick = 0;
		for (int i = `RS_SIZE - 1; i >= 0; i--) begin     // lowest slot is oldest
			if (i < count_q && a_rdy_q[i] && b_rdy_q[i]) begin
				found = 1'b1;
				pick = i;
			end
		end
	end

	assign issue_valid = found && ready;
	assign issue_op = op_q[pick];
	assign issue_a = a_q[pick];
	assign issue_b = b_q[pick];
	assign issue_dest = dest_q[pick];
	assign issue_rob = rob_q[pick];

	assign full = count_q == CW'(`RS_SIZE);
	assign load_pos = count_q - CW'(issue_valid);        // first free slot after the shift

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else begin
			count_q <= load_pos + CW'(load);
		end
	end

	always_ff @(posedge clock) begin
		int src;
		logic hit_a;
		logic hit_b;
		for (int i = 0; i < `RS_SIZE; i++) begin
			src = (issue_valid && i >= pick) ? i + 1 : i;   // close the gap
			if (src < `RS_SIZE) begin
				hit_a = cdb_valid && !a_rdy_q[src] && tag_a_q[src] == cdb_tag;
				hit_b = cdb_valid && !b_rdy_q[src] && tag_b_q[src] == cdb_tag;
				op_q[i] <= op_q[src];
				a_q[i] <= hit_a ? cdb_value : a_q[src];         // wake up on tag match
				b_q[i] <= hit_b ? cdb_value : b_q[src];
				a_rdy_q[i] <= a_rdy_q[src] || hit_a;
				b_rdy_q[i] <= b_rdy_q[src] || hit_b;
				tag_a_q[i] <= tag_a_q[src];
				tag_b_q[i] <= tag_b_q[src];
				dest_q[i] <= dest_q[src];
				rob_q[i] <= rob_q[src];
			end
			if (load && i == load_pos) begin
				op_q[i] <= load_op;
				a_q[i] <= load_a;
				b_q[i] <= load_b;
				a_rdy_q[i] <= load_a_rdy;
				b_rdy_q[i] <= load_b_rdy;
				tag_a_q[i] <= load_tag_a;
				tag_b_q[i] <= load_tag_b;
				dest_q[i] <= load_dest;
				rob_q[i] <= load_rob;
			end
		end
	end

endmodule

// File: hdl/alu_unit.sv
`include "core_settings.svh"

module alu_unit import core_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     issue_valid,
	input  alu_op_t  issue_op,
	input  word_t    issue_a,
	input  word_t    issue_b,
	input  prn_t     issue_dest,
	input  rob_idx_t issue_rob,
	input  logic     grant,          // cdb takes the result
	output logic     ready,
	output logic     res_valid,
	output word_t    res_value,
	output prn_t     res_tag,
	output rob_idx_t res_rob
);

	word_t result;

	always_comb begin
		case (issue_op)
			ALU_ADD: result = issue_a + issue_b;
			ALU_SUB: result = issue_a - issue_b;
			ALU_AND: result = issue_a & issue_b;
			ALU_OR:  result = issue_a | issue_b;
			ALU_XOR: result = issue_a ^ issue_b;
			ALU_SLL: result = issue_a << issue_b[$clog2(`XLEN)-1:0];
			ALU_SRL: result = issue_a >> issue_b[$clog2(`XLEN)-1:0];
			ALU_SLT: result = word_t'($signed(issue_a) < $signed(issue_b));
			default: result = '0;
		endcase
	end

	assign ready = !res_valid || grant;                   // slot frees as the cdb takes it

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (ready) begin
			res_valid <= issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid && ready) begin
			res_value <= result;
			res_tag <= issue_dest;
			res_rob <= issue_rob;
		end
	end

endmodule

// File: hdl/mult_pipe.sv
`include "core_settings.svh"

module mult_pipe import core_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     issue_valid,
	input  mult_op_t issue_op,
	input  word_t    issue_a,
	input  word_t    issue_b,
	input  prn_t     issue_dest,
	input  rob_idx_t issue_rob,
	output logic     res_valid,
	output word_t    res_value,
	output prn_t     res_tag,
	output rob_idx_t res_rob
);

	localparam int LAST = `MULT_STAGES - 1;

	logic [2*`XLEN-1:0] product;
	logic [2*`XLEN-1:0] prod_q [`MULT_STAGES];
	logic [`MULT_STAGES-1:0] valid_q;
	mult_op_t op_q  [`MULT_STAGES];
	prn_t     tag_q [`MULT_STAGES];
	rob_idx_t rob_q [`MULT_STAGES];

	assign product = issue_a * issue_b;                   // full width, unsigned

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[LAST-1:0], issue_valid};     // never stalls
		end
	end

	always_ff @(posedge clock) begin
		prod_q[0] <= product;
		op_q[0] <= issue_op;
		tag_q[0] <= issue_dest;
		rob_q[0] <= issue_rob;
		for (int s = 1; s < `MULT_STAGES; s++) begin
			prod_q[s] <= prod_q[s-1];
			op_q[s] <= op_q[s-1];
			tag_q[s] <= tag_q[s-1];
			rob_q[s] <= rob_q[s-1];
		end
	end

	// half select at the last stage
	assign res_valid = valid_q[LAST];
	assign res_value = (op_q[LAST] == MUL_HI) ? prod_q[LAST][2*`XLEN-1:`XLEN]
		: prod_q[LAST][`XLEN-1:0];
	assign res_tag = tag_q[LAST];
	assign res_rob = rob_q[LAST];

endmodule

// File: hdl/reorder_buffer.sv
`include "core_settings.svh"

module reorder_buffer import core_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     alloc,
	input  arn_t     alloc_arn,
	input  prn_t     alloc_prn,      // dest prn, 0 when rd is r0
	input  prn_t     alloc_old,      // mapping to free at retire
	input  logic     alloc_wr,
	output rob_idx_t alloc_idx,
	output logic     full,
	input  logic     cdb_valid,
	input  rob_idx_t cdb_rob_idx,
	output logic     commit_valid,
	output arn_t     commit_arn,
	output logic     commit_wr_en,
	output prn_t     commit_prn,
	output logic     release_en,
	output prn_t     release_prn
);

	localparam int CW = $clog2(`ROB_SIZE + 1);

	arn_t arn_q [`ROB_SIZE];
	prn_t prn_q [`ROB_SIZE];
	prn_t old_q [`ROB_SIZE];
	logic wr_q  [`ROB_SIZE];
	logic [`ROB_SIZE-1:0] done_q;    // cleared again as the slot retires
	rob_idx_t head_q;                // oldest entry
	rob_idx_t tail_q;                // next free slot
	logic [CW-1:0] count_q;

	assign alloc_idx = tail_q;
	assign full = count_q == CW'(`ROB_SIZE);

	assign commit_valid = done_q[head_q];
	assign commit_arn = arn_q[head_q];
	assign commit_wr_en = wr_q[head_q];
	assign commit_prn = prn_q[head_q];
	assign release_en = commit_valid && wr_q[head_q];
	assign release_prn = old_q[head_q];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			done_q <= '0;
		end else begin
			if (alloc) begin
				tail_q <= tail_q + 1'b1;                      // wraps at the power of two
			end
			if (cdb_valid) begin
				done_q[cdb_rob_idx] <= 1'b1;
			end
			if (commit_valid) begin
				head_q <= head_q + 1'b1;
				done_q[head_q] <= 1'b0;                       // slot is empty for the next alloc
			end
			count_q <= count_q + CW'(alloc) - CW'(commit_valid);
		end
	end

	always_ff @(posedge clock) begin
		if (alloc) begin
			arn_q[tail_q] <= alloc_arn;
			prn_q[tail_q] <= alloc_prn;
			old_q[tail_q] <= alloc_old;
			wr_q[tail_q] <= alloc_wr;
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		commit_valid |-> count_q != '0);

	// each unit result completes a live entry exactly once
	assert property (@(posedge clock) disable iff (!rst_n)
		cdb_valid |-> !done_q[cdb_rob_idx]);

endmodule

// File: hdl/ooo_core.sv
`include "core_settings.svh"

module ooo_core import core_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	input  logic  wb_cyc,
	input  logic  wb_stb,
	input  logic  wb_we,
	input  word_t wb_wdata,          // pre-decoded dispatch word
	output logic  wb_ack,
	output logic  commit_valid,
	output arn_t  commit_arn,
	output logic  commit_wr_en,
	output word_t commit_value
);

	opcode_t  opcode;
	arn_t     rd;
	arn_t     ra;
	arn_t     rb;
	word_t    imm;
	logic     is_mult;
	logic     wr_rd;
	logic     can_go;
	logic     disp;
	prn_t     src_a;
	prn_t     src_b;
	prn_t     new_prn;
	prn_t     old_prn;
	prn_t     dest_prn;
	logic     free_empty;
	word_t    val_a;
	word_t    val_b;
	logic     rdy_a;
	logic     rdy_b;
	logic     rob_full;
	rob_idx_t rob_idx;
	prn_t     commit_prn;
	logic     release_en;
	prn_t     release_prn;
	logic     alu_full;
	logic     mult_full;
	logic     alu_iss_valid;
	alu_op_t  alu_iss_op;
	word_t    alu_iss_a;
	word_t    alu_iss_b;
	prn_t     alu_iss_dest;
	rob_idx_t alu_iss_rob;
	logic     mul_iss_valid;
	mult_op_t mul_iss_op;
	word_t    mul_iss_a;
	word_t    mul_iss_b;
	prn_t     mul_iss_dest;
	rob_idx_t mul_iss_rob;
	logic     alu_ready;
	logic     alu_grant;
	logic     alu_res_valid;
	word_t    alu_res_value;
	prn_t     alu_res_tag;
	rob_idx_t alu_res_rob;
	logic     mul_res_valid;
	word_t    mul_res_value;
	prn_t     mul_res_tag;
	rob_idx_t mul_res_rob;
	logic     cdb_valid;
	prn_t     cdb_tag;
	word_t    cdb_value;
	rob_idx_t cdb_rob_idx;

////////////////////////////////////////////////////////////////////////////
// dispatch

	assign opcode = opcode_t'(wb_wdata[31:28]);
	assign rd = wb_wdata[27:25];
	assign ra = wb_wdata[24:22];
	assign rb = wb_wdata[21:19];
	assign imm = {{(`XLEN - 16){wb_wdata[15]}}, wb_wdata[15:0]};
	assign is_mult = opcode inside {OP_MUL_LO, OP_MUL_HI};  // spare codes fall to the alu
	assign wr_rd = rd != '0;
	assign dest_prn = wr_rd ? new_prn : '0;

	assign can_go = !rob_full && (is_mult ? !mult_full : !alu_full) && (!free_empty || !wr_rd);
	assign wb_ack = wb_cyc && wb_stb && (!wb_we || can_go);  // reads ack at once
	assign disp = wb_cyc && wb_stb && wb_we && can_go;

	rename_map rename_map_i (
		.clock(clock), .rst_n(rst_n),
		.alloc(disp && wr_rd), .rd(rd), .ra(ra), .rb(rb),
		.src_a(src_a), .src_b(src_b), .new_prn(new_prn), .old_prn(old_prn),
		.free_empty(free_empty),
		.release_en(release_en), .release_prn(release_prn)
	);

	phys_regfile phys_regfile_i (
		.clock(clock), .rst_n(rst_n),
		.rd_a(src_a), .rd_b(src_b),
		.val_a(val_a), .val_b(val_b), .rdy_a(rdy_a), .rdy_b(rdy_b),
		.alloc(disp && wr_rd), .alloc_prn(new_prn),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.commit_prn(commit_prn), .commit_value(commit_value)
	);

////////////////////////////////////////////////////////////////////////////
// issue and execute

	reservation_station #(.op_t(alu_op_t)) alu_rs (
		.clock(clock), .rst_n(rst_n),
		.load(disp && !is_mult), .load_op(alu_op_t'(opcode[2:0])),
		.load_a(val_a), .load_b(wb_wdata[18] ? imm : val_b),
		.load_a_rdy(rdy_a), .load_b_rdy(wb_wdata[18] || rdy_b),
		.load_tag_a(src_a), .load_tag_b(src_b),
		.load_dest(dest_prn), .load_rob(rob_idx), .full(alu_full),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.ready(alu_ready),
		.issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
		.issue_a(alu_iss_a), .issue_b(alu_iss_b),
		.issue_dest(alu_iss_dest), .issue_rob(alu_iss_rob)
	);

	reservation_station #(.op_t(mult_op_t)) mult_rs (
		.clock(clock), .rst_n(rst_n),
		.load(disp && is_mult), .load_op(mult_op_t'(opcode[0])),
		.load_a(val_a), .load_b(wb_wdata[18] ? imm : val_b),
		.load_a_rdy(rdy_a), .load_b_rdy(wb_wdata[18] || rdy_b),
		.load_tag_a(src_a), .load_tag_b(src_b),
		.load_dest(dest_prn), .load_rob(rob_idx), .full(mult_full),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.ready(1'b1),                                       // pipeline takes one per cycle
		.issue_valid(mul_iss_valid), .issue_op(mul_iss_op),
		.issue_a(mul_iss_a), .issue_b(mul_iss_b),
		.issue_dest(mul_iss_dest), .issue_rob(mul_iss_rob)
	);

	alu_unit alu_unit_i (
		.clock(clock), .rst_n(rst_n),
		.issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
		.issue_a(alu_iss_a), .issue_b(alu_iss_b),
		.issue_dest(alu_iss_dest), .issue_rob(alu_iss_rob),
		.grant(alu_grant), .ready(alu_ready),
		.res_valid(alu_res_valid), .res_value(alu_res_value),
		.res_tag(alu_res_tag), .res_rob(alu_res_rob)
	);

	mult_pipe mult_pipe_i (
		.clock(clock), .rst_n(rst_n),
		.issue_valid(mul_iss_valid), .issue_op(mul_iss_op),
		.issue_a(mul_iss_a), .issue_b(mul_iss_b),
		.issue_dest(mul_iss_dest), .issue_rob(mul_iss_rob),
		.res_valid(mul_res_valid), .res_value(mul_res_value),
		.res_tag(mul_res_tag), .res_rob(mul_res_rob)
	);

////////////////////////////////////////////////////////////////////////////
// cdb and retirement

	assign alu_grant = !mul_res_valid;                    // multiplier cannot stall
	assign cdb_valid = mul_res_valid || alu_res_valid;
	assign cdb_tag = mul_res_valid ? mul_res_tag : alu_res_tag;
	assign cdb_value = mul_res_valid ? mul_res_value : alu_res_value;
	assign cdb_rob_idx = mul_res_valid ? mul_res_rob : alu_res_rob;

	reorder_buffer reorder_buffer_i (
		.clock(clock), .rst_n(rst_n),
		.alloc(disp), .alloc_arn(rd), .alloc_prn(dest_prn),
		.alloc_old(old_prn), .alloc_wr(wr_rd),
		.alloc_idx(rob_idx), .full(rob_full),
		.cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx),
		.commit_valid(commit_valid), .commit_arn(commit_arn),
		.commit_wr_en(commit_wr_en), .commit_prn(commit_prn),
		.release_en(release_en), .release_prn(release_prn)
	);

	// one unit owns the bus per cycle, the losing alu result waits unchanged
	assert property (@(posedge clock) disable iff (!rst_n)
		alu_res_valid && !alu_grant |=>
			alu_res_valid && $stable(alu_res_tag) && $stable(alu_res_rob));

endmodule

// File: testbench/ooo_core_tb.sv
`include "core_settings.svh"

module ooo_core_tb import core_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_INSTR = 243;                     // dispatches summed over all tests
	localparam int CYCLES_PER_INSTR = 40;
	localparam int DRAIN_LIMIT = 500;                   // cycles to empty the pipeline

	logic  clock;
	logic  rst_n;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	word_t wb_wdata;
	logic  wb_ack;
	logic  commit_valid;
	arn_t  commit_arn;
	logic  commit_wr_en;
	word_t commit_value;

	word_t  model_regs [`ARCH_REGS];                    // architectural state in program order
	arn_t   exp_arn [$];                                // expected commits, oldest first
	logic   exp_wr [$];
	word_t  exp_val [$];
	int     errors;
	int     checks;
	int     stall_cycles;                               // posedges with stb high and no ack
	int     sent;
	integer seed;

	ooo_core ooo_core_i (
		.clock(clock), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_wdata(wb_wdata),
		.wb_ack(wb_ack),
		.commit_valid(commit_valid), .commit_arn(commit_arn),
		.commit_wr_en(commit_wr_en), .commit_value(commit_value)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(CLK_PERIOD * (NUM_INSTR * CYCLES_PER_INSTR + 10));
		$display("ERROR watchdog expired, the core stopped acking or committing");
		$display("TESTBENCH FAILED");
		$finish;
	end

////////////////////////////////////////////////////////////////////////////
// reference model

	// result of one instruction from the isa rules
	function automatic word_t expected_result(input opcode_t op, input word_t a, input word_t b);
		logic [2*`XLEN-1:0] prod;
		prod = (2*`XLEN)'(a) * (2*`XLEN)'(b);          // unsigned full product
		case (op)
			OP_ADD:    return a + b;
			OP_SUB:    return a - b;
			OP_AND:    return a & b;
			OP_OR:     return a | b;
			OP_XOR:    return a ^ b;
			OP_SLL:    return a << b[4:0];              // shift amount is the low five bits
			OP_SRL:    return a >> b[4:0];
			OP_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_MUL_LO: return prod[`XLEN-1:0];
			OP_MUL_HI: return prod[2*`XLEN-1:`XLEN];
			default:   return '0;
		endcase
	endfunction

	// one wishbone write, stb stays up so the next word can follow at once
	task automatic dispatch(input word_t word);
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_wdata = word;
		@(posedge clock);
		while (!wb_ack) begin
			stall_cycles++;                             // back-pressure, word held
			@(posedge clock);
		end
	endtask

	task automatic send_instr(input opcode_t op, input arn_t rd, input arn_t ra, input arn_t rb,
		input logic use_imm, input logic [15:0] imm);
		word_t b;
		word_t res;
		b = use_imm ? {{(`XLEN - 16){imm[15]}}, imm} : model_regs[rb];
		res = expected_result(op, model_regs[ra], b);
		if (rd == '0) begin
			res = '0;                                   // r0 commits as zero
		end else begin
			model_regs[rd] = res;
		end
		exp_arn.push_back(rd);
		exp_wr.push_back(rd != '0);
		exp_val.push_back(res);
		dispatch({op, rd, ra, rb, use_imm, 2'b00, imm});
		sent++;
	endtask

	task automatic bus_idle();
		@(negedge clock);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// wait for every outstanding instruction to retire
	task automatic drain();
		int waited;
		waited = 0;
		bus_idle();
		while (exp_arn.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		if (exp_arn.size() != 0) begin
			errors++;
			$display("ERROR t=%0t %0d instructions never committed", $time, exp_arn.size());
		end
	endtask

	// commit monitor, in-order compare against the model queue
	always @(posedge clock) begin
		if (rst_n && commit_valid) begin
			if (exp_arn.size() == 0) begin
				errors++;
				$display("ERROR t=%0t commit with no instruction outstanding", $time);
			end else begin
				checks++;
				if (commit_arn !== exp_arn[0]) begin
					errors++;
					$display("FAIL t=%0t commit_arn got %0d expected %0d",
						$time, commit_arn, exp_arn[0]);
				end
				if (commit_wr_en !== exp_wr[0]) begin
					errors++;
					$display("FAIL t=%0t commit_wr_en got %b expected %b",
						$time, commit_wr_en, exp_wr[0]);
				end
				if (commit_value !== exp_val[0]) begin
					errors++;
					$display("FAIL t=%0t commit_value got %h expected %h",
						$time, commit_value, exp_val[0]);
				end
				void'(exp_arn.pop_front());
				void'(exp_wr.pop_front());
				void'(exp_val.pop_front());
			end
		end
	end

////////////////////////////////////////////////////////////////////////////
// directed tests

	task automatic test_reset_state();
		@(negedge clock);
		checks++;
		if (wb_ack !== 1'b0) begin
			errors++;
			$display("FAIL t=%0t wb_ack got %b expected 0", $time, wb_ack);
		end
		if (commit_valid !== 1'b0) begin
			errors++;
			$display("FAIL t=%0t commit_valid got %b expected 0", $time, commit_valid);
		end
		wb_cyc = 1'b1;                                  // read cycle carrying a live-looking word
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_wdata = {OP_ADD, 3'd1, 3'd0, 3'd0, 1'b1, 2'b00, 16'h0055};
		@(posedge clock);
		if (wb_ack !== 1'b1) begin
			errors++;
			$display("FAIL t=%0t wb_ack got %b expected 1", $time, wb_ack);
		end
		bus_idle();
		repeat (6) begin
			@(negedge clock);
			if (commit_valid !== 1'b0) begin
				errors++;
				$display("FAIL t=%0t commit_valid got %b expected 0", $time, commit_valid);
			end
		end
	endtask

	task automatic test_alu_ops();
		send_instr(OP_ADD, 3'd1, 3'd0, 3'd0, 1'b1, 16'h8765);   // negative after sign extension
		send_instr(OP_ADD, 3'd2, 3'd0, 3'd0, 1'b1, 16'h0005);
		for (int i = 0; i < 8; i++) begin
			send_instr(opcode_t'(i), 3'd3, 3'd1, 3'd2, 1'b0, 16'h0000);
			send_instr(opcode_t'(i), 3'd4, 3'd1, 3'd0, 1'b1, 16'hfff3);
		end
		drain();
	endtask

	// the alu ops behind the multiply finish first but must retire after it
	task automatic test_mul_order();
		send_instr(OP_ADD, 3'd1, 3'd0, 3'd0, 1'b1, 16'h7123);
		send_instr(OP_SLL, 3'd1, 3'd1, 3'd0, 1'b1, 16'd12);
		send_instr(OP_ADD, 3'd2, 3'd0, 3'd0, 1'b1, 16'hfffd);
		send_instr(OP_MUL_HI, 3'd3, 3'd1, 3'd2, 1'b0, 16'h0000);
		send_instr(OP_ADD, 3'd4, 3'd3, 3'd1, 1'b0, 16'h0000);  // waits on the multiply
		send_instr(OP_XOR, 3'd5, 3'd1, 3'd2, 1'b0, 16'h0000);
		send_instr(OP_SUB, 3'd6, 3'd2, 3'd1, 1'b0, 16'h0000);
		send_instr(OP_OR, 3'd7, 3'd1, 3'd0, 1'b1, 16'h00f0);
		drain();
	endtask

	task automatic test_rob_stall();
		int stalls_before;
		stalls_before = stall_cycles;
		send_instr(OP_ADD, 3'd1, 3'd0, 3'd0, 1'b1, 16'h0003);
		repeat (12) begin
			send_instr(OP_MUL_LO, 3'd1, 3'd1, 3'd0, 1'b1, 16'h0005);  // chain through r1
		end
		checks++;
		if (stall_cycles == stalls_before) begin
			errors++;
			$display("ERROR t=%0t twelve dependent multiplies never stalled the ack", $time);
		end
		drain();
	endtask

	task automatic test_r0_writes();
		send_instr(OP_ADD, 3'd0, 3'd1, 3'd0, 1'b1, 16'h0007);
		send_instr(OP_MUL_LO, 3'd0, 3'd1, 3'd1, 1'b0, 16'h0000);
		send_instr(OP_ADD, 3'd2, 3'd0, 3'd0, 1'b1, 16'h0005);   // r0 source reads zero
		send_instr(OP_OR, 3'd3, 3'd0, 3'd0, 1'b0, 16'h0000);
		drain();
	endtask

	task automatic test_random();
		opcode_t op;
		arn_t rd;
		arn_t ra;
		arn_t rb;
		logic use_imm;
		logic [15:0] imm;
		repeat (200) begin
			op = opcode_t'($unsigned($random(seed)) % 10);     // codes 10 to 15 unused
			rd = arn_t'($random(seed));
			ra = arn_t'($random(seed));
			rb = arn_t'($random(seed));
			use_imm = 1'($random(seed));
			imm = 16'($random(seed));
			send_instr(op, rd, ra, rb, use_imm, imm);
		end
		drain();
	endtask

////////////////////////////////////////////////////////////////////////////
// sequence

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_wdata = '0;
		errors = 0;
		checks = 0;
		stall_cycles = 0;
		sent = 0;
		seed = 40595;
		for (int i = 0; i < `ARCH_REGS; i++) begin
			model_regs[i] = '0;                         // reset maps every register to zero
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		test_reset_state();
		test_alu_ops();
		test_mul_order();
		test_rob_stall();
		test_r0_writes();
		test_random();

		$display("instructions=%0d checks=%0d stalls=%0d errors=%0d",
			sent, checks, stall_cycles, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+hdl
hdl/core_pkg.sv
hdl/rename_map.sv
hdl/phys_regfile.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/mult_pipe.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
testbench/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/rename_map.sv
      - hdl/phys_regfile.sv
      - hdl/reservation_station.sv
      - hdl/alu_unit.sv
      - hdl/mult_pipe.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_core.sv
  - target: simulation
    files:
      - testbench/ooo_core_tb.sv
